// File: vlog.f
mpeg_pkg.sv
mpeg_ifs.sv
dclk_timer.sv
dma_sequencer.sv
byte_splitter.sv
host_regs.sv
vmpeg_ctrl.sv
tb_vmpeg.sv

// File: run.sh
#!/usr/bin/env bash
# Compile and run the vmpeg_ctrl testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_vmpeg -f vlog.f -o tb_vmpeg_sim > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat build.log
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/tb_vmpeg_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

# Pass only if the testbench printed its pass line
if grep -q "^RESULT: PASS$" sim.log; then
    exit 0
fi
exit 1

// File: tb_vmpeg.sv
`timescale 1ns/1ps
`default_nettype none

module tb_vmpeg
    import mpeg_pkg::*;
();

    localparam int DIV = int'(DCLK_DIVIDER);
    // Timer and DCLK tests dominate, the rest is a few hundred cycles
    localparam int RUN_CYCLES = 9 * DIV + 8 * DIV + 4000;

    logic        clk;
    logic        reset;
    logic [23:1] address;
    logic [15:0] din;
    logic        uds;
    logic        lds;
    logic        write_strobe;
    logic        cs;
    logic        intack;
    logic        ack;
    logic        dtc;
    logic        done_in;
    logic        vsync;
    logic        fma_event_dec_start;
    logic        fma_event_frame;
    logic        fma_event_underflow;
    logic        fmv_event_seq;
    logic        fmv_event_pic;
    logic        fmv_event_eod;
    logic        fmv_event_end;
    logic        fmv_event_underflow;
    logic [15:0] dout;
    logic        bus_ack;
    logic        intreq;
    logic        req;
    logic        rdy;
    logic [7:0]  stream_data;
    logic        stream_valid;
    logic        stream_fma;

    // Model of the interrupt and status registers
    logic [15:0] m_fma_isr;
    logic [15:0] m_fma_ier;
    logic [15:0] m_fma_stat;
    logic [15:0] m_fma_ivec;
    logic [15:0] m_fmv_isr;
    logic [15:0] m_fmv_ier;
    logic [15:0] m_fmv_ivec;
    logic [15:0] m_tcnt;

    logic [8:0]  exp_bytes[$];  // {stream_fma, byte}
    logic [15:0] rd_data;
    logic [15:0] dclk_hi[2];
    logic [15:0] dclk_lo[2];
    logic [31:0] dclk_delta;
    int          dclk_at[2];
    int          errors;
    int          checks;
    int          cycle;
    int          ack_cycle;
    int          start_cycle;
    int          reset_cycle;
    fmv_irq_word_u tim_word;

    vmpeg_ctrl dut0 (
        .clk, .reset, .address, .din, .uds, .lds, .write_strobe, .cs, .intack,
        .ack, .dtc, .done_in, .vsync,
        .fma_event_dec_start, .fma_event_frame, .fma_event_underflow,
        .fmv_event_seq, .fmv_event_pic, .fmv_event_eod, .fmv_event_end,
        .fmv_event_underflow,
        .dout, .bus_ack, .intreq, .req, .rdy, .stream_data, .stream_valid, .stream_fma
    );

    always #5 clk = ~clk;

    always @(posedge clk)
        cycle <= cycle + 1;

    function automatic logic ref_intreq(input logic [15:0] fma_isr, input logic [15:0] fma_ier,
                                        input logic [15:0] fmv_isr, input logic [15:0] fmv_ier);
        return (|(fma_isr & fma_ier)) || (|(fmv_isr & fmv_ier));
    endfunction

    // FMA vector wins when its request is pending
    function automatic logic [15:0] ref_vector(input logic fma_pending,
                                               input logic [15:0] fma_ivec,
                                               input logic [15:0] fmv_ivec);
        if (fma_pending)
            return {fma_ivec[7:0], fma_ivec[7:0]};
        return {fmv_ivec[10:3], fmv_ivec[10:3]};
    endfunction

    function automatic logic [15:0] event_mask(input int which);
        fmv_irq_word_u w;
        w.raw = 16'h0000;
        case (which)
            0: w.raw[FMA_BIT_DEC] = 1'b1;
            1: w.raw[FMA_BIT_UPD] = 1'b1;
            2: w.raw[FMA_BIT_UNF] = 1'b1;
            3: w.flags.seq = 1'b1;
            4: w.flags.pic = 1'b1;
            5: w.flags.eod = 1'b1;
            6: w.flags.esi = 1'b1;   // End of stream event
            7: w.flags.ndat = 1'b1;  // Video underflow
            default: w.flags.vsync = 1'b1;
        endcase
        return w.raw;
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error: %s is %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    // One CPU access, waits for the toggling acknowledge
    task automatic access_register(input logic [14:0] waddr, input logic wr,
                                   input logic [15:0] wdata, output logic [15:0] rdata);
        int wait_cnt;
        @(posedge clk);
        #1;
        address      = {8'hE0, waddr};
        din          = wdata;
        write_strobe = wr;
        uds          = 1'b1;
        lds          = 1'b1;
        cs           = 1'b1;
        wait_cnt     = 0;
        while (bus_ack !== 1'b1 && wait_cnt < 8) begin
            @(posedge clk);
            #1;
            wait_cnt++;
        end
        if (bus_ack !== 1'b1) begin
            errors++;
            $display("Bus access to word address %h was never acknowledged", waddr);
        end
        rdata = dout;
        @(posedge clk);
        #1;
        ack_cycle    = cycle;  // Edge where the access took effect
        cs           = 1'b0;
        uds          = 1'b0;
        lds          = 1'b0;
        write_strobe = 1'b0;
    endtask

    task automatic bus_write(input logic [14:0] waddr, input logic [15:0] wdata);
        logic [15:0] unused;
        access_register(waddr, 1'b1, wdata, unused);
    endtask

    task automatic bus_read(input logic [14:0] waddr, output logic [15:0] rdata);
        access_register(waddr, 1'b0, 16'h0000, rdata);
    endtask

    task automatic expect_reg(input logic [14:0] waddr, input logic [15:0] exp, input string name);
        logic [15:0] got;
        bus_read(waddr, got);
        check(name, got, exp);
    endtask

    task automatic fire_event(input int which);
        @(posedge clk);
        #1;
        case (which)
            0: fma_event_dec_start = 1'b1;
            1: fma_event_frame     = 1'b1;
            2: fma_event_underflow = 1'b1;
            3: fmv_event_seq       = 1'b1;
            4: fmv_event_pic       = 1'b1;
            5: fmv_event_eod       = 1'b1;
            6: fmv_event_end       = 1'b1;
            7: fmv_event_underflow = 1'b1;
            default: vsync         = 1'b1;
        endcase
        @(posedge clk);
        #1;
        {fma_event_dec_start, fma_event_frame, fma_event_underflow} = 3'b000;
        {fmv_event_seq, fmv_event_pic, fmv_event_eod, fmv_event_end} = 4'b0000;
        fmv_event_underflow = 1'b0;
        vsync               = 1'b0;
    endtask

    task automatic check_vector();
        @(posedge clk);
        #1;
        intack = 1'b1;
        @(negedge clk);
        check("dout (vector)", dout,
              ref_vector(|(m_fma_isr & m_fma_ier), m_fma_ivec, m_fmv_ivec));
        @(posedge clk);
        #1;
        intack = 1'b0;
    endtask

    task automatic send_word(input logic [15:0] w, input logic fma);
        exp_bytes.push_back({fma, w[15:8]});
        exp_bytes.push_back({fma, w[7:0]});
        @(posedge clk);
        #1;
        din = w;
        ack = 1'b1;
        dtc = 1'b1;
        @(posedge clk);
        #1;
        ack = 1'b0;
        dtc = 1'b0;
    endtask

    task automatic finish_dma();
        @(posedge clk);
        #1;
        done_in = 1'b1;
        ack     = 1'b1;
        @(posedge clk);
        #1;
        done_in = 1'b0;
        ack     = 1'b0;
        check("req", req, 1'b0);
        check("rdy", rdy, 1'b0);
    endtask

    task automatic check_dma_start();
        check("req", req, 1'b0);  // Start pulse still in flight
        @(posedge clk);
        #1;
        check("req", req, 1'b1);
        check("rdy", rdy, 1'b1);
    endtask

    // Every stream byte against the expected queue
    always @(negedge clk) begin : stream_compare
        logic [8:0] e;
        if (!reset && stream_valid === 1'b1) begin
            if (exp_bytes.size() == 0) begin
                errors++;
                $display("Stream byte %h appeared with no byte expected", stream_data);
            end else begin
                e = exp_bytes.pop_front();
                check("stream_data", stream_data, e[7:0]);
                check("stream_fma", stream_fma, e[8]);
            end
        end
    end

    initial begin
        #(RUN_CYCLES * 2 * 10);
        $display("Timeout: the run did not finish within %0d cycles", RUN_CYCLES * 2);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        address = '0;
        din = '0;
        {uds, lds, write_strobe, cs, intack} = 5'b00000;
        {ack, dtc, done_in, vsync} = 4'b0000;
        {fma_event_dec_start, fma_event_frame, fma_event_underflow} = 3'b000;
        {fmv_event_seq, fmv_event_pic, fmv_event_eod, fmv_event_end} = 4'b0000;
        fmv_event_underflow = 1'b0;
        errors = 0;
        checks = 0;
        cycle = 0;
        void'($urandom(10435));
        m_fma_isr = '0;
        m_fmv_isr = '0;
        m_fma_stat = '0;

        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        reset_cycle = cycle;  // DCLK ticks count from here
        check("bus_ack", bus_ack, 1'b0);
        check("req", req, 1'b0);
        check("rdy", rdy, 1'b0);
        check("intreq", intreq, 1'b0);
        check("stream_valid", stream_valid, 1'b0);

        // Register readback with random words
        m_fma_ier  = 16'($urandom);
        m_fma_ivec = 16'($urandom);
        m_fmv_ier  = 16'($urandom);
        m_fmv_ivec = 16'($urandom);
        m_tcnt     = 16'($urandom) | 16'h8000;  // Far beyond any timer hit here
        bus_write(FMA_IER_ADDR, m_fma_ier);
        bus_write(FMA_IVEC_ADDR, m_fma_ivec);
        bus_write(FMV_IER_ADDR, m_fmv_ier);
        bus_write(FMV_IVEC_ADDR, m_fmv_ivec);
        bus_write(FMV_TCNT_ADDR, m_tcnt);
        expect_reg(FMA_IER_ADDR, m_fma_ier, "fma_ier");
        expect_reg(FMA_IVEC_ADDR, m_fma_ivec, "fma_ivec");
        expect_reg(FMV_IER_ADDR, m_fmv_ier, "fmv_ier");
        expect_reg(FMV_IVEC_ADDR, m_fmv_ivec, "fmv_ivec");
        expect_reg(FMV_TCNT_ADDR, m_tcnt, "fmv_tcnt");

        // Events and vsync, some enabled and some not
        m_fma_ier = 16'h0114;
        m_fmv_ier = 16'h0B0C;
        bus_write(FMA_IER_ADDR, m_fma_ier);
        bus_write(FMV_IER_ADDR, m_fmv_ier);
        for (int i = 0; i < 9; i++) begin
            fire_event(i);
            if (i < 3)
                m_fma_isr = m_fma_isr | event_mask(i);
            else
                m_fmv_isr = m_fmv_isr | event_mask(i);
            case (i)
                0: m_fma_stat[FMA_BIT_DEC] = 1'b1;
                1: begin
                    m_fma_stat[FMA_BIT_DEC] = 1'b0;
                    m_fma_stat[FMA_BIT_UPD] = 1'b1;
                end
                2: m_fma_stat[FMA_BIT_UNF] = 1'b1;
                default: ;
            endcase
            check("intreq", intreq, ref_intreq(m_fma_isr, m_fma_ier, m_fmv_isr, m_fmv_ier));
            check_vector();
            if (i < 3) begin
                expect_reg(FMA_STAT_ADDR, m_fma_stat, "fma_stat");
                expect_reg(FMA_ISR_ADDR, m_fma_isr, "fma_isr");
                m_fma_isr = '0;
                expect_reg(FMA_ISR_ADDR, 16'h0000, "fma_isr after read");
            end else begin
                expect_reg(FMV_ISR_ADDR, m_fmv_isr, "fmv_isr");
                m_fmv_isr = '0;
                expect_reg(FMV_ISR_ADDR, 16'h0000, "fmv_isr after read");
            end
            check("intreq", intreq, ref_intreq(m_fma_isr, m_fma_ier, m_fmv_isr, m_fmv_ier));
        end

        // Timer with compare 1, nine DCLK ticks after the reload
        bus_write(FMA_IER_ADDR, 16'h0100);
        bus_write(FMV_IER_ADDR, 16'h0100);
        bus_write(FMV_TCNT_ADDR, 16'h0001);
        // Reload lands on a DCLK tick edge, so the next tick is a full period away
        while ((cycle + 3 - reset_cycle) % DIV != 0) begin
            @(posedge clk);
            #1;
        end
        bus_write(FMV_TRLD_ADDR, 16'h0000);
        start_cycle = ack_cycle;
        while (intreq !== 1'b1 && cycle - start_cycle < 9 * DIV + 10) begin
            @(posedge clk);
            #1;
        end
        if (intreq !== 1'b1) begin
            errors++;
            $display("Timer interrupt never arrived after the reload");
        end else if (cycle - start_cycle < 9 * DIV - 2 || cycle - start_cycle > 9 * DIV + 2) begin
            errors++;
            $display("Timer hit came %0d cycles after the reload", cycle - start_cycle);
        end
        tim_word.raw = 16'h0000;
        tim_word.flags.tim = 1'b1;
        expect_reg(FMA_ISR_ADDR, 16'h0001 << FMA_BIT_POLL, "fma_isr timer");
        expect_reg(FMV_ISR_ADDR, tim_word.raw, "fmv_isr timer");
        bus_write(FMV_TCNT_ADDR, 16'hFFFF);
        bus_write(FMA_IER_ADDR, 16'h0000);
        bus_write(FMV_IER_ADDR, 16'h0000);

        // DCLK latch and rate
        bus_read(FMA_DCLKH_ADDR, dclk_hi[0]);
        dclk_at[0] = ack_cycle;
        bus_read(FMA_DCLKL_ADDR, dclk_lo[0]);
        repeat (2 * DIV) @(posedge clk);
        expect_reg(FMA_DCLKL_ADDR, dclk_lo[0], "dclkl held");
        repeat (3 * DIV) @(posedge clk);
        bus_read(FMA_DCLKH_ADDR, dclk_hi[1]);
        dclk_at[1] = ack_cycle;
        bus_read(FMA_DCLKL_ADDR, dclk_lo[1]);
        dclk_delta = {dclk_hi[1], dclk_lo[1]} - {dclk_hi[0], dclk_lo[0]};
        if (int'(dclk_delta) < (dclk_at[1] - dclk_at[0]) / DIV ||
            int'(dclk_delta) > (dclk_at[1] - dclk_at[0]) / DIV + 1) begin
            errors++;
            $display("DCLK advanced %0d ticks over %0d cycles", dclk_delta,
                     dclk_at[1] - dclk_at[0]);
        end

        // FMA DMA with random words
        bus_write(FMA_CMD_ADDR, 16'h8002);
        check_dma_start();
        for (int i = 0; i < 6; i++)
            send_word(16'($urandom), 1'b1);
        finish_dma();
        expect_reg(FMA_CMD_ADDR, 16'h0002, "fma_cmd after done");

        // FMV DMA, then one XFER register word
        bus_write(FMV_SYSCMD_ADDR, 16'h8000);
        check_dma_start();
        for (int i = 0; i < 4; i++)
            send_word(16'($urandom), 1'b0);
        finish_dma();
        rd_data = 16'($urandom);
        exp_bytes.push_back({1'b0, rd_data[15:8]});
        exp_bytes.push_back({1'b0, rd_data[7:0]});
        bus_write(FMV_XFER_ADDR, rd_data);

        repeat (4) @(posedge clk);
        if (exp_bytes.size() != 0) begin
            errors++;
            $display("%0d expected stream bytes never appeared", exp_bytes.size());
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: vmpeg_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module vmpeg_ctrl (
    input wire          clk,
    input wire          reset,
    input wire  [23:1]  address,
    input wire  [15:0]  din,
    input wire          uds,
    input wire          lds,
    input wire          write_strobe,
    input wire          cs,
    input wire          intack,
    input wire          ack,
    input wire          dtc,
    input wire          done_in,
    input wire          vsync,
    input wire          fma_event_dec_start,
    input wire          fma_event_frame,
    input wire          fma_event_underflow,
    input wire          fmv_event_seq,
    input wire          fmv_event_pic,
    input wire          fmv_event_eod,
    input wire          fmv_event_end,
    input wire          fmv_event_underflow,
    output logic [15:0] dout,
    output logic        bus_ack,
    output logic        intreq,
    output logic        req,
    output logic        rdy,
    output logic [7:0]  stream_data,
    output logic        stream_valid,
    output logic        stream_fma
);

    logic word_strobe;
    logic word_fma;

    dma_ctl_if dma_bus ();
    timer_if   tmr_bus ();

    host_regs regs0 (
        .clk, .reset, .address, .din, .uds, .lds, .write_strobe, .cs, .intack, .vsync,
        .fma_event_dec_start, .fma_event_frame, .fma_event_underflow,
        .fmv_event_seq, .fmv_event_pic, .fmv_event_eod, .fmv_event_end,
        .fmv_event_underflow,
        .dout, .bus_ack, .intreq,
        .dma (dma_bus.regs),
        .tmr (tmr_bus.regs)
    );

    dclk_timer timer0 (
        .clk, .reset,
        .tmr (tmr_bus.timer)
    );

    dma_sequencer seq0 (
        .clk, .reset, .ack, .dtc, .done_in,
        .dma (dma_bus.seq),
        .req, .rdy, .word_strobe, .word_fma
    );

    byte_splitter split0 (
        .clk, .reset, .din, .word_strobe, .word_fma,
        .stream_data, .stream_valid, .stream_fma
    );

endmodule

`default_nettype wire

// File: host_regs.sv
`timescale 1ns/1ps
`default_nettype none

module host_regs
    import mpeg_pkg::*;
(
    input wire          clk,
    input wire          reset,
    input wire  [23:1]  address,
    input wire  [15:0]  din,
    input wire          uds,
    input wire          lds,
    input wire          write_strobe,
    input wire          cs,
    input wire          intack,
    input wire          vsync,
    input wire          fma_event_dec_start,
    input wire          fma_event_frame,
    input wire          fma_event_underflow,
    input wire          fmv_event_seq,
    input wire          fmv_event_pic,
    input wire          fmv_event_eod,
    input wire          fmv_event_end,
    input wire          fmv_event_underflow,
    output logic [15:0] dout,
    output logic        bus_ack,
    output logic        intreq,
    dma_ctl_if.regs     dma,
    timer_if.regs       tmr
);

    logic          access;
    logic          rd_cycle;
    logic          wr_cycle;
    logic [14:0]   word_addr;
    logic          vsync_q;
    logic          fma_intreq;
    logic          fmv_intreq;

    logic [15:0]   fma_cmd;
    logic [15:0]   fma_stat;
    logic [15:0]   fma_isr;
    logic [15:0]   fma_ier;
    logic [15:0]   fma_ivec;
    logic [15:0]   dclkl_latch;

    logic [15:0]   fmv_ier;
    fmv_irq_word_u fmv_isr;
    logic [15:0]   fmv_tcnt;
    logic [15:0]   fmv_syscmd;
    logic [15:0]   fmv_ivec;

    assign access    = cs && (uds || lds);
    assign word_addr = address[15:1];
    assign rd_cycle  = access && bus_ack && !write_strobe;
    assign wr_cycle  = access && bus_ack && write_strobe;

    assign fma_intreq = |(fma_isr & fma_ier);
    assign fmv_intreq = |(fmv_isr.raw & fmv_ier);
    assign intreq     = fma_intreq || fmv_intreq;

    assign tmr.compare    = fmv_tcnt;
    assign tmr.reload     = wr_cycle && (word_addr == FMV_TRLD_ADDR);
    assign dma.xfer_write = wr_cycle && (word_addr == FMV_XFER_ADDR);

    always_comb begin
        dout = 16'h0000;
        case (word_addr)
            FMA_CMD_ADDR:    dout = fma_cmd;
            FMA_STAT_ADDR:   dout = fma_stat;
            FMA_IVEC_ADDR:   dout = fma_ivec;
            FMA_DCLKH_ADDR:  dout = tmr.dclk[31:16];
            FMA_DCLKL_ADDR:  dout = dclkl_latch;
            FMA_ISR_ADDR:    dout = fma_isr;
            FMA_IER_ADDR:    dout = fma_ier;
            FMV_IER_ADDR:    dout = fmv_ier;
            FMV_ISR_ADDR:    dout = fmv_isr.raw;
            FMV_TCNT_ADDR:   dout = fmv_tcnt;
            FMV_SYSCMD_ADDR: dout = fmv_syscmd;
            FMV_IVEC_ADDR:   dout = fmv_ivec;
            default: ;
        endcase

        // Vector fetch, FMA wins when both are pending
        if (intack) begin
            if (fma_intreq)
                dout = {fma_ivec[7:0], fma_ivec[7:0]};
            else
                dout = {fmv_ivec[10:3], fmv_ivec[10:3]};
        end
    end

    // Low half frozen when the CPU fetches the high half
    always_ff @(posedge clk) begin
        if (rd_cycle && word_addr == FMA_DCLKH_ADDR)
            dclkl_latch <= tmr.dclk[15:0];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            bus_ack       <= 1'b0;
            vsync_q       <= 1'b0;
            dma.start_fma <= 1'b0;
            dma.start_fmv <= 1'b0;
            fma_cmd       <= '0;
            fma_stat      <= '0;
            fma_isr       <= '0;
            fma_ier       <= '0;
            fma_ivec      <= '0;
            fmv_ier       <= '0;
            fmv_isr.raw   <= '0;
            fmv_tcnt      <= TCNT_RESET;
            fmv_syscmd    <= '0;
            fmv_ivec      <= '0;
        end else begin
            bus_ack <= access ? !bus_ack : 1'b0;  // Toggles while selected
            vsync_q <= vsync;

            dma.start_fma <= wr_cycle && (word_addr == FMA_CMD_ADDR) && din[CMD_DMA_BIT];
            dma.start_fmv <= wr_cycle && (word_addr == FMV_SYSCMD_ADDR) && din[CMD_DMA_BIT];

            if (vsync && !vsync_q)
                fmv_isr.flags.vsync <= 1'b1;
            if (fmv_event_seq)
                fmv_isr.flags.seq <= 1'b1;
            if (fmv_event_pic)
                fmv_isr.flags.pic <= 1'b1;
            if (fmv_event_eod)
                fmv_isr.flags.eod <= 1'b1;
            if (fmv_event_end)
                fmv_isr.flags.esi <= 1'b1;
            if (fmv_event_underflow)
                fmv_isr.flags.ndat <= 1'b1;

            if (fma_event_dec_start) begin
                fma_stat[FMA_BIT_DEC] <= 1'b1;
                fma_isr[FMA_BIT_DEC]  <= 1'b1;
            end
            if (fma_event_frame) begin
                fma_stat[FMA_BIT_DEC] <= 1'b0;  // Decoding now running
                fma_stat[FMA_BIT_UPD] <= 1'b1;
                fma_isr[FMA_BIT_UPD]  <= 1'b1;
            end
            if (fma_event_underflow) begin
                fma_stat[FMA_BIT_UNF] <= 1'b1;
                fma_isr[FMA_BIT_UNF]  <= 1'b1;
            end

            // One timer drives both units
            if (tmr.timer_hit) begin
                fmv_isr.flags.tim     <= 1'b1;
                fma_isr[FMA_BIT_POLL] <= 1'b1;
            end

            if (dma.done)
                fma_cmd[CMD_DMA_BIT] <= 1'b0;

            // Read clears the ISR, later events are lost that cycle
            if (rd_cycle && word_addr == FMA_ISR_ADDR)
                fma_isr <= '0;
            if (rd_cycle && word_addr == FMV_ISR_ADDR)
                fmv_isr.raw <= '0;

            if (wr_cycle) begin
                case (word_addr)
                    FMA_CMD_ADDR:    fma_cmd    <= din;
                    FMA_IVEC_ADDR:   fma_ivec   <= din;
                    FMA_IER_ADDR:    fma_ier    <= din;
                    FMV_IER_ADDR:    fmv_ier    <= din;
                    FMV_TCNT_ADDR:   fmv_tcnt   <= din;
                    FMV_SYSCMD_ADDR: fmv_syscmd <= din;
                    FMV_IVEC_ADDR:   fmv_ivec   <= din;
                    default: ;
                endcase
            end
        end
    end

    a_ack_toggle: assert property (@(posedge clk) disable iff (reset)
        bus_ack |=> !bus_ack);

endmodule

`default_nettype wire

// File: byte_splitter.sv
`timescale 1ns/1ps
`default_nettype none

module byte_splitter (
    input wire         clk,
    input wire         reset,
    input wire  [15:0] din,
    input wire         word_strobe,
    input wire         word_fma,
    output logic [7:0] stream_data,
    output logic       stream_valid,
    output logic       stream_fma
);

    logic       low_pending;
    logic [7:0] low_byte;
    logic       low_fma;

    always_ff @(posedge clk) begin
        if (reset)
            low_pending <= 1'b0;
        else
            low_pending <= word_strobe;
    end

    always_ff @(posedge clk) begin
        if (word_strobe) begin
            low_byte <= din[7:0];
            low_fma  <= word_fma;
        end
    end

    // High byte straight from the bus, low byte one cycle later
    assign stream_valid = word_strobe || low_pending;
    assign stream_data  = low_pending ? low_byte : din[15:8];
    assign stream_fma   = low_pending ? low_fma : word_fma;

    a_word_gap: assert property (@(posedge clk) disable iff (reset)
        word_strobe |=> !word_strobe);

endmodule

`default_nettype wire

// File: dma_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module dma_sequencer
    import mpeg_pkg::*;
(
    input wire    clk,
    input wire    reset,
    input wire    ack,
    input wire    dtc,
    input wire    done_in,
    dma_ctl_if.seq dma,
    output logic  req,
    output logic  rdy,
    output logic  word_strobe,
    output logic  word_fma
);

    logic [1:0] state;
    logic       busy;

    assign busy = (state != ST_IDLE);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (dma.start_fma)
                        state <= ST_FMA;
                    else if (dma.start_fmv)
                        state <= ST_FMV;
                end
                ST_FMA, ST_FMV: begin
                    if (done_in && ack)
                        state <= ST_IDLE;  // Host ends the transfer
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    assign req = busy;
    assign rdy = busy;

    assign dma.busy = busy;
    assign dma.done = busy && done_in && ack;

    // XFER writes share the byte path, tagged as video
    assign word_strobe = (busy && ack && dtc) || dma.xfer_write;
    assign word_fma    = (state == ST_FMA);

    a_no_restart: assert property (@(posedge clk) disable iff (reset)
        dma.busy |-> !(dma.start_fma || dma.start_fmv));

endmodule

`default_nettype wire

// File: dclk_timer.sv
`timescale 1ns/1ps
`default_nettype none

module dclk_timer
    import mpeg_pkg::*;
(
    input wire      clk,
    input wire      reset,
    timer_if.timer  tmr
);

    logic [9:0]                   div_cnt;
    logic [31:0]                  dclk_cnt;
    logic [15+TIMER_FRAC_BITS:0]  timer_cnt;  // Low bits are the fraction
    logic                         tick;
    logic                         match;

    assign tick  = (div_cnt == DCLK_DIVIDER - 10'd1);
    assign match = (timer_cnt[15+TIMER_FRAC_BITS:TIMER_FRAC_BITS] == tmr.compare);

    assign tmr.dclk      = dclk_cnt;
    assign tmr.timer_hit = tick && match;

    always_ff @(posedge clk) begin
        if (reset) begin
            div_cnt   <= '0;
            dclk_cnt  <= '0;
            timer_cnt <= '0;
        end else begin
            if (tick) begin
                div_cnt  <= '0;
                dclk_cnt <= dclk_cnt + 32'd1;
                if (match)
                    timer_cnt <= '0;  // Restart period
                else
                    timer_cnt <= timer_cnt + 1'b1;
            end else begin
                div_cnt <= div_cnt + 10'd1;
            end

            // TRLD write restarts the period from zero
            if (tmr.reload)
                timer_cnt <= '0;
        end
    end

    a_div_range: assert property (@(posedge clk) disable iff (reset)
        div_cnt < DCLK_DIVIDER);

endmodule

`default_nettype wire

// File: mpeg_ifs.sv
`timescale 1ns/1ps
`default_nettype none

// DMA control between register bank and sequencer
interface dma_ctl_if;
    logic start_fma;   // Registered pulse after CMD write
    logic start_fmv;   // Registered pulse after SYSCMD write
    logic xfer_write;  // Same cycle as the XFER bus write
    logic busy;
    logic done;        // Transfer finished, clears CMD bit 15

    modport regs (
        output start_fma, start_fmv, xfer_write,
        input  busy, done
    );

    modport seq (
        input  start_fma, start_fmv, xfer_write,
        output busy, done
    );
endinterface

// Time base to register bank
interface timer_if;
    logic [31:0] dclk;
    logic        timer_hit;
    logic [15:0] compare;
    logic        reload;

    modport timer (
        output dclk, timer_hit,
        input  compare, reload
    );

    modport regs (
        input  dclk, timer_hit,
        output compare, reload
    );
endinterface

`default_nettype wire

// File: mpeg_pkg.sv
`default_nettype none

package mpeg_pkg;

    // Register word addresses, matched against address[15:1]
    localparam logic [14:0] FMA_CMD_ADDR    = 15'h1800;  // 0xE03000
    localparam logic [14:0] FMA_STAT_ADDR   = 15'h1801;  // 0xE03002
    localparam logic [14:0] FMA_IVEC_ADDR   = 15'h1806;  // 0xE0300C
    localparam logic [14:0] FMA_DCLKH_ADDR  = 15'h1808;  // 0xE03010
    localparam logic [14:0] FMA_DCLKL_ADDR  = 15'h1809;  // 0xE03012
    localparam logic [14:0] FMA_ISR_ADDR    = 15'h180D;  // 0xE0301A
    localparam logic [14:0] FMA_IER_ADDR    = 15'h180E;  // 0xE0301C

    localparam logic [14:0] FMV_IER_ADDR    = 15'h2030;  // 0xE04060
    localparam logic [14:0] FMV_ISR_ADDR    = 15'h2031;  // 0xE04062
    localparam logic [14:0] FMV_TCNT_ADDR   = 15'h2032;  // 0xE04064
    localparam logic [14:0] FMV_TRLD_ADDR   = 15'h2057;  // 0xE040AE
    localparam logic [14:0] FMV_SYSCMD_ADDR = 15'h2060;  // 0xE040C0
    localparam logic [14:0] FMV_IVEC_ADDR   = 15'h206E;  // 0xE040DC
    localparam logic [14:0] FMV_XFER_ADDR   = 15'h206F;  // 0xE040DE

    // System clock to 45 kHz
    localparam logic [9:0] DCLK_DIVIDER = 10'd667;

    // Timer runs 8x finer than the compare register
    localparam int TIMER_FRAC_BITS = 3;
    localparam logic [15:0] TCNT_RESET = 16'd55;  // About 10 ms

    // FMA status and interrupt bits
    localparam int FMA_BIT_UPD  = 2;  // Frame header updated
    localparam int FMA_BIT_UNF  = 3;  // Underflow
    localparam int FMA_BIT_DEC  = 4;  // Decoding started
    localparam int FMA_BIT_POLL = 8;  // Timer poll

    localparam int CMD_DMA_BIT = 15;

    // DMA sequencer states
    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_FMA  = 2'd1;
    localparam logic [1:0] ST_FMV  = 2'd2;

    typedef struct packed {
        logic erdv;
        logic erdd;
        logic vcup;
        logic pai;    // Pause
        logic vsync;  // Vertical sync edge
        logic eii;    // End of ISO stream
        logic esi;    // End of sequence
        logic tim;    // System timer
        logic dcl;
        logic ovf;
        logic ndat;   // Decoder starved
        logic rfb;
        logic eod;    // End of data
        logic pic;    // Picture decoded
        logic gop;
        logic seq;    // Sequence header
    } fmv_irq_flags_s;

    // Set by name, read and masked as a word
    typedef union packed {
        fmv_irq_flags_s flags;
        logic [15:0]    raw;
    } fmv_irq_word_u;

endpackage

`default_nettype wire
